//--- common/sniff_settings.svh
`ifndef SNIFF_SETTINGS_SVH
`define SNIFF_SETTINGS_SVH

// widths
`define SNIFF_BYTE_WIDTH       8
`define SNIFF_PATTERN_BYTES    8   // bytes in the match window
`define SNIFF_DELAY_WIDTH      20
`define SNIFF_WIDTH_WIDTH      17
`define SNIFF_COUNT_WIDTH      8
`define SNIFF_APB_ADDR_WIDTH   8
`define SNIFF_APB_DATA_WIDTH   32

// APB register map
`define SNIFF_REG_PATTERN_LO   8'h00
`define SNIFF_REG_PATTERN_HI   8'h04
`define SNIFF_REG_MASK_LO      8'h08
`define SNIFF_REG_MASK_HI      8'h0C
`define SNIFF_REG_DELAY        8'h10
`define SNIFF_REG_WIDTH        8'h14
`define SNIFF_REG_CTRL         8'h18   // bit 0 arm, write 1 to arm
`define SNIFF_REG_STATUS       8'h1C   // bit 0 armed, 15:8 trigger count

`endif

//--- common/sniff_pkg.sv
`include "sniff_settings.svh"

package sniff_pkg;

   typedef logic [`SNIFF_BYTE_WIDTH-1:0]                       byte_t;

   // byte 0 is the oldest byte in the window
   typedef logic [`SNIFF_PATTERN_BYTES*`SNIFF_BYTE_WIDTH-1:0]  pattern_t;

   typedef logic [`SNIFF_DELAY_WIDTH-1:0]                      delay_t;    // fe_clk cycles
   typedef logic [`SNIFF_WIDTH_WIDTH-1:0]                      width_t;    // fe_clk cycles
   typedef logic [`SNIFF_APB_ADDR_WIDTH-1:0]                   apb_addr_t;
   typedef logic [`SNIFF_APB_DATA_WIDTH-1:0]                   apb_data_t;
   typedef logic [`SNIFF_COUNT_WIDTH-1:0]                      trig_count_t;

   typedef enum logic [1:0] {
      TRIG_IDLE,    // not armed
      TRIG_ARMED,   // collecting matches per packet
      TRIG_DELAY,   // counting down the delay
      TRIG_PULSE    // driving the trigger output
   } trig_state_e;

endpackage

//--- src/apb_regs.sv
`default_nettype none
`timescale 1ns/10ps
`include "sniff_settings.svh"

module apb_regs (
   input  logic                   fe_clk,
   input  logic                   reset_i,
   input  sniff_pkg::apb_addr_t   paddr_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  sniff_pkg::apb_data_t   pwdata_i,
   input  logic                   armed_i,
   input  sniff_pkg::trig_count_t trig_count_i,
   output sniff_pkg::apb_data_t   prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output sniff_pkg::pattern_t    pattern_o,
   output sniff_pkg::pattern_t    mask_o,
   output sniff_pkg::delay_t      delay_o,
   output sniff_pkg::width_t      width_o,
   output logic                   arm_set_o
);
   import sniff_pkg::*;

   logic access;   // APB access phase
   logic mapped;
   logic wr_en;

   assign access    = psel_i & penable_i;
   assign wr_en     = access & pwrite_i & mapped;
   assign pready_o  = 1'b1;               // no wait states
   assign pslverr_o = access & ~mapped;

   // arm takes effect at the access edge
   assign arm_set_o = wr_en & (paddr_i == `SNIFF_REG_CTRL) & pwdata_i[0];

   ////////////////////////////////////////
   // address decode and read mux
   ////////////////////////////////////////
   always_comb begin
      mapped   = 1'b1;
      prdata_o = '0;
      case (paddr_i)
         `SNIFF_REG_PATTERN_LO: prdata_o = pattern_o[31:0];
         `SNIFF_REG_PATTERN_HI: prdata_o = pattern_o[63:32];
         `SNIFF_REG_MASK_LO:    prdata_o = mask_o[31:0];
         `SNIFF_REG_MASK_HI:    prdata_o = mask_o[63:32];
         `SNIFF_REG_DELAY:      prdata_o = apb_data_t'(delay_o);
         `SNIFF_REG_WIDTH:      prdata_o = apb_data_t'(width_o);
         `SNIFF_REG_CTRL:       prdata_o = apb_data_t'(armed_i);
         `SNIFF_REG_STATUS:     prdata_o = apb_data_t'({trig_count_i, 7'b0, armed_i});
         default:               mapped   = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // configuration registers
   ////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         pattern_o <= '0;
         mask_o    <= '0;
         delay_o   <= '0;
         width_o   <= '0;
      end
      else if (wr_en) begin
         case (paddr_i)
            `SNIFF_REG_PATTERN_LO: pattern_o[31:0]  <= pwdata_i;
            `SNIFF_REG_PATTERN_HI: pattern_o[63:32] <= pwdata_i;
            `SNIFF_REG_MASK_LO:    mask_o[31:0]     <= pwdata_i;
            `SNIFF_REG_MASK_HI:    mask_o[63:32]    <= pwdata_i;
            `SNIFF_REG_DELAY:      delay_o <= pwdata_i[`SNIFF_DELAY_WIDTH-1:0];
            `SNIFF_REG_WIDTH:      width_o <= pwdata_i[`SNIFF_WIDTH_WIDTH-1:0];
            default: ;                           // CTRL and STATUS hold no config
         endcase
      end
   end

endmodule
`default_nettype wire

//--- trigger/pattern_matcher.sv
`default_nettype none
`timescale 1ns/10ps
`include "sniff_settings.svh"

module pattern_matcher (
   input  logic                fe_clk,
   input  logic                reset_i,
   input  sniff_pkg::byte_t    fe_data_i,
   input  logic                fe_rxvalid_i,
   input  logic                fe_rxactive_i,
   input  sniff_pkg::pattern_t pattern_i,
   input  sniff_pkg::pattern_t mask_i,
   output logic                match_o
);
   import sniff_pkg::*;

   localparam int NBYTES = `SNIFF_PATTERN_BYTES;
   localparam int BW     = $bits(byte_t);

   pattern_t          window_q;
   logic [NBYTES-1:0] filled_q;      // slot holds a byte of this packet
   logic              active_q;
   pattern_t          window_base;
   logic [NBYTES-1:0] filled_base;
   pattern_t          window_next;
   logic [NBYTES-1:0] filled_next;
   logic [NBYTES-1:0] byte_hit;
   logic              pkt_start;
   logic              accept;

   assign pkt_start = fe_rxactive_i & ~active_q;
   assign accept    = fe_rxvalid_i & fe_rxactive_i;

   // new byte enters at the top, oldest falls out of byte 0
   always_comb begin
      window_base = pkt_start ? '0 : window_q;
      filled_base = pkt_start ? '0 : filled_q;
      window_next = {fe_data_i, window_base[NBYTES*BW-1:BW]};
      filled_next = {1'b1, filled_base[NBYTES-1:1]};
   end

   ////////////////////////////////////////
   // bytewise masked compare
   ////////////////////////////////////////
   always_comb begin
      for (int i = 0; i < NBYTES; i++) begin
         // an empty slot only passes when fully masked off
         byte_hit[i] = (((window_next[i*BW +: BW] ^ pattern_i[i*BW +: BW])
                         & mask_i[i*BW +: BW]) == '0)
                       && (filled_next[i] || (mask_i[i*BW +: BW] == '0));
      end
   end

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         active_q <= 1'b0;
         filled_q <= '0;
         match_o  <= 1'b0;
      end
      else begin
         active_q <= fe_rxactive_i;
         match_o  <= accept & (&byte_hit);   // one cycle per accepted byte
         if (accept)
            filled_q <= filled_next;
         else if (pkt_start)
            filled_q <= '0;
      end
   end

   always_ff @(posedge fe_clk) begin
      if (accept)
         window_q <= window_next;
      else if (pkt_start)
         window_q <= '0;                     // cleared at packet start
   end

endmodule
`default_nettype wire

//--- trigger/packet_monitor.sv
`default_nettype none
`timescale 1ns/10ps

module packet_monitor (
   input  logic fe_clk,
   input  logic reset_i,
   input  logic fe_rxactive_i,
   input  logic fe_rxerror_i,
   output logic pkt_end_o,
   output logic pkt_err_o
);

   logic active_q;   // rxactive from the previous edge
   logic err_q;      // error seen so far in this packet
   logic pkt_done;

   assign pkt_done = active_q & ~fe_rxactive_i;

   ////////////////////////////////////////
   // end of packet and sticky error
   ////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         active_q  <= 1'b0;
         err_q     <= 1'b0;
         pkt_end_o <= 1'b0;
         pkt_err_o <= 1'b0;
      end
      else begin
         active_q  <= fe_rxactive_i;
         pkt_end_o <= pkt_done;
         if (pkt_done) begin
            // error on the closing edge still counts
            pkt_err_o <= err_q | fe_rxerror_i;
            err_q     <= 1'b0;
         end
         else begin
            pkt_err_o <= 1'b0;
            if (fe_rxactive_i & fe_rxerror_i)
               err_q <= 1'b1;
         end
      end
   end

endmodule
`default_nettype wire

//--- trigger/trigger_gen.sv
`default_nettype none
`timescale 1ns/10ps

module trigger_gen (
   input  logic                   fe_clk,
   input  logic                   reset_i,
   input  logic                   arm_set_i,
   input  logic                   match_i,
   input  logic                   pkt_end_i,
   input  logic                   pkt_err_i,
   input  sniff_pkg::delay_t      delay_i,
   input  sniff_pkg::width_t      width_i,
   output logic                   cw_trig_o,
   output logic                   armed_o,
   output sniff_pkg::trig_count_t trig_count_o
);
   import sniff_pkg::*;

   trig_state_e state_q;
   logic        match_seen_q;   // match latched in the current packet
   delay_t      delay_cnt_q;
   width_t      width_cnt_q;
   width_t      width_last;

   // zero width acts as one cycle
   assign width_last = (width_i == '0) ? '0 : width_i - width_t'(1);
   assign armed_o    = (state_q != TRIG_IDLE);

   ////////////////////////////////////////
   // trigger FSM
   ////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         state_q      <= TRIG_IDLE;
         match_seen_q <= 1'b0;
         cw_trig_o    <= 1'b0;
         trig_count_o <= '0;
      end
      else begin
         case (state_q)
            TRIG_IDLE: begin
               if (arm_set_i) begin
                  state_q      <= TRIG_ARMED;
                  match_seen_q <= 1'b0;
               end
            end
            TRIG_ARMED: begin
               if (pkt_end_i) begin
                  match_seen_q <= 1'b0;         // fresh start for the next packet
                  if (match_seen_q && !pkt_err_i)
                     state_q <= TRIG_DELAY;
               end
               else if (match_i) begin
                  match_seen_q <= 1'b1;
               end
            end
            TRIG_DELAY: begin
               if (delay_cnt_q == '0) begin
                  state_q   <= TRIG_PULSE;
                  cw_trig_o <= 1'b1;
               end
            end
            TRIG_PULSE: begin
               if (width_cnt_q == '0) begin
                  state_q      <= TRIG_IDLE;    // one-shot disarm
                  cw_trig_o    <= 1'b0;
                  trig_count_o <= trig_count_o + trig_count_t'(1);   // wraps at 255
               end
            end
            default: state_q <= TRIG_IDLE;
         endcase
      end
   end

   // counters only matter in DELAY and PULSE
   always_ff @(posedge fe_clk) begin
      case (state_q)
         TRIG_ARMED: delay_cnt_q <= delay_i;   // loaded until the packet qualifies
         TRIG_DELAY: begin
            delay_cnt_q <= delay_cnt_q - delay_t'(1);
            width_cnt_q <= width_last;
         end
         TRIG_PULSE: width_cnt_q <= width_cnt_q - width_t'(1);
         default: ;
      endcase
   end

endmodule
`default_nettype wire

//--- src/sniff_top.sv
`default_nettype none
`timescale 1ns/10ps

module sniff_top (
   input  logic                 fe_clk,
   input  logic                 reset_i,
   input  sniff_pkg::apb_addr_t paddr_i,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  sniff_pkg::apb_data_t pwdata_i,
   output sniff_pkg::apb_data_t prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   input  sniff_pkg::byte_t     fe_data_i,
   input  logic                 fe_rxvalid_i,
   input  logic                 fe_rxactive_i,
   input  logic                 fe_rxerror_i,
   output logic                 cw_trig_o,
   output logic                 mcx_trig_o
);
   import sniff_pkg::*;

   pattern_t    pattern;
   pattern_t    mask;
   delay_t      delay;
   width_t      width;
   logic        arm_set;
   logic        armed;
   trig_count_t trig_count;
   logic        match;
   logic        pkt_end;
   logic        pkt_err;
   logic        trig;        // shared by both trigger connectors

   assign cw_trig_o  = trig;
   assign mcx_trig_o = trig;

   ////////////////////////////////////////
   // configuration
   ////////////////////////////////////////
   apb_regs U_apb_regs (
      .fe_clk       (fe_clk),
      .reset_i      (reset_i),
      .paddr_i      (paddr_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .pwdata_i     (pwdata_i),
      .armed_i      (armed),
      .trig_count_i (trig_count),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .pattern_o    (pattern),
      .mask_o       (mask),
      .delay_o      (delay),
      .width_o      (width),
      .arm_set_o    (arm_set)
   );

   ////////////////////////////////////////
   // trigger path
   ////////////////////////////////////////
   pattern_matcher U_pattern_matcher (
      .fe_clk        (fe_clk),
      .reset_i       (reset_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .pattern_i     (pattern),
      .mask_i        (mask),
      .match_o       (match)
   );

   packet_monitor U_packet_monitor (
      .fe_clk        (fe_clk),
      .reset_i       (reset_i),
      .fe_rxactive_i (fe_rxactive_i),
      .fe_rxerror_i  (fe_rxerror_i),
      .pkt_end_o     (pkt_end),
      .pkt_err_o     (pkt_err)
   );

   trigger_gen U_trigger_gen (
      .fe_clk       (fe_clk),
      .reset_i      (reset_i),
      .arm_set_i    (arm_set),
      .match_i      (match),
      .pkt_end_i    (pkt_end),
      .pkt_err_i    (pkt_err),
      .delay_i      (delay),
      .width_i      (width),
      .cw_trig_o    (trig),
      .armed_o      (armed),
      .trig_count_o (trig_count)
   );

endmodule
`default_nettype wire

//--- test/tb_sniff.sv
`timescale 1ns/10ps
`include "sniff_settings.svh"

module tb_sniff;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   localparam int TAIL_CYCLES  = 60;   // closing unmapped-address checks
   localparam int NROWS        = 6;

   localparam logic [63:0] PAT_A = 64'h1E2D_3C4B_5A69_7887;
   localparam logic [63:0] MSK_A = 64'hFFFF_F0FF_00FF_0FFF;   // byte 0 fully compared
   localparam logic [63:0] PAT_B = 64'hC3D2_E1F0_0F1E_2D3C;
   localparam logic [63:0] MSK_B = 64'hFFFF_FFFF_FFFF_FFFF;

   logic        fe_clk;
   logic        reset_i;
   logic [7:0]  paddr_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic [7:0]  fe_data_i;
   logic        fe_rxvalid_i;
   logic        fe_rxactive_i;
   logic        fe_rxerror_i;
   logic        cw_trig_o;
   logic        mcx_trig_o;

   // stimulus table with one entry per test
   string       row_name    [NROWS];
   logic [63:0] row_pattern [NROWS];
   logic [63:0] row_mask    [NROWS];
   logic [31:0] row_delay   [NROWS];
   logic [31:0] row_width   [NROWS];
   logic        row_arm     [NROWS];
   logic [63:0] row_body    [NROWS];   // byte 0 is sent first
   int          row_pre     [NROWS];   // filler bytes before the body
   int          row_post    [NROWS];   // filler bytes after the body
   logic        row_err     [NROWS];
   logic        row_trig    [NROWS];

   string cur_test = "reset";
   int    checks   = 0;
   int    errors   = 0;
   int    seed     = 63483;
   logic  rows_loaded = 1'b0;

   sniff_top DUT (
      .fe_clk        (fe_clk),
      .reset_i       (reset_i),
      .paddr_i       (paddr_i),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .pwdata_i      (pwdata_i),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .fe_rxerror_i  (fe_rxerror_i),
      .cw_trig_o     (cw_trig_o),
      .mcx_trig_o    (mcx_trig_o)
   );

   initial begin
      fe_clk = 1'b0;
      forever #(CLK_PERIOD/2) fe_clk = ~fe_clk;
   end

   task automatic set_row(input int i, input string name, input logic [63:0] pat,
                          input logic [63:0] msk, input int dly, input int wid,
                          input logic arm, input logic [63:0] body, input int pre,
                          input int post, input logic err, input logic trig);
      row_name[i]    = name;
      row_pattern[i] = pat;
      row_mask[i]    = msk;
      row_delay[i]   = 32'(dly);
      row_width[i]   = 32'(wid);
      row_arm[i]     = arm;
      row_body[i]    = body;
      row_pre[i]     = pre;
      row_post[i]    = post;
      row_err[i]     = err;
      row_trig[i]    = trig;
   endtask

   task automatic load_table();
      //      name                pattern mask   dly wid arm body
      //      pre post err trig
      set_row(0, "masked_match",     PAT_A, MSK_A, 5,  3,  1, PAT_A ^ ~MSK_A,
              3, 2, 0, 1);
      set_row(1, "error_packet",     PAT_A, MSK_A, 5,  3,  1, PAT_A,
              2, 2, 1, 0);
      set_row(2, "no_match",         PAT_B, MSK_B, 4,  2,  0, PAT_B ^ 64'h0000_0100_0000_0000,
              1, 3, 0, 0);
      set_row(3, "zero_delay_width", PAT_B, MSK_B, 0,  0,  0, PAT_B,
              0, 0, 0, 1);
      set_row(4, "not_rearmed",      PAT_A, MSK_A, 3,  2,  0, PAT_A,
              2, 1, 0, 0);
      set_row(5, "rearmed",          PAT_A, MSK_A, 12, 7,  1, PAT_A ^ ~MSK_A,
              4, 0, 0, 1);
   endtask

   ////////////////////////////////////////
   // checking helpers
   ////////////////////////////////////////
   task automatic compare_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      assert (act === exp)
      else begin
         errors++;
         $display("mismatch in %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
      end
   endtask

   // armed in bit 0 and trigger count in bits 15:8
   function automatic logic [31:0] status_word(input logic armed, input logic [7:0] count);
      return {16'b0, count, 7'b0, armed};
   endfunction

   function automatic logic [7:0] next_filler(input logic [7:0] avoid);
      logic [31:0] rnd;
      rnd = $random(seed);
      if (rnd[7:0] == avoid)
         rnd[7:0] = rnd[7:0] ^ 8'h01;   // never the first pattern byte
      return rnd[7:0];
   endfunction

   ////////////////////////////////////////
   // APB driver entered and left at a falling edge
   ////////////////////////////////////////
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      paddr_i   = addr;
      pwdata_i  = data;
      pwrite_i  = 1'b1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      @(negedge fe_clk);
      penable_i = 1'b1;
      #(CLK_PERIOD/4);
      err = pslverr_o;
      compare_value("pready on write", 32'h1, 32'(pready_o));
      @(negedge fe_clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      paddr_i   = addr;
      pwrite_i  = 1'b0;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      @(negedge fe_clk);
      penable_i = 1'b1;
      #(CLK_PERIOD/4);   // middle of the access phase
      data = prdata_o;
      err  = pslverr_o;
      compare_value("pready on read", 32'h1, 32'(pready_o));
      @(negedge fe_clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      logic err;
      apb_write(addr, data, err);
      compare_value("pslverr on write", 32'h0, 32'(err));
   endtask

   task automatic read_check(input string what, input logic [7:0] addr,
                             input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_read(addr, rd, err);
      compare_value({what, " pslverr"}, 32'h0, 32'(err));
      compare_value(what, exp, rd);
   endtask

   task automatic readback_row(input int i);
      read_check("pattern_lo", `SNIFF_REG_PATTERN_LO, row_pattern[i][31:0]);
      read_check("pattern_hi", `SNIFF_REG_PATTERN_HI, row_pattern[i][63:32]);
      read_check("mask_lo", `SNIFF_REG_MASK_LO, row_mask[i][31:0]);
      read_check("mask_hi", `SNIFF_REG_MASK_HI, row_mask[i][63:32]);
      read_check("delay", `SNIFF_REG_DELAY, row_delay[i]);
      read_check("width", `SNIFF_REG_WIDTH, row_width[i]);
   endtask

   task automatic configure_row(input int i);
      write_reg(`SNIFF_REG_PATTERN_LO, row_pattern[i][31:0]);
      write_reg(`SNIFF_REG_PATTERN_HI, row_pattern[i][63:32]);
      write_reg(`SNIFF_REG_MASK_LO, row_mask[i][31:0]);
      write_reg(`SNIFF_REG_MASK_HI, row_mask[i][63:32]);
      write_reg(`SNIFF_REG_DELAY, row_delay[i]);
      write_reg(`SNIFF_REG_WIDTH, row_width[i]);
      readback_row(i);
   endtask

   ////////////////////////////////////////
   // front end driver and trigger checker
   ////////////////////////////////////////
   task automatic send_packet(input int i);
      fe_rxactive_i = 1'b1;   // one idle cycle before the first byte
      fe_rxvalid_i  = 1'b0;
      @(negedge fe_clk);
      for (int k = 0; k < row_pre[i]; k++) begin
         fe_data_i    = next_filler(row_pattern[i][7:0]);
         fe_rxvalid_i = 1'b1;
         @(negedge fe_clk);
      end
      for (int k = 0; k < 8; k++) begin
         fe_data_i    = row_body[i][k*8 +: 8];
         fe_rxvalid_i = 1'b1;
         fe_rxerror_i = row_err[i] && (k == 4);   // single error cycle mid packet
         @(negedge fe_clk);
      end
      fe_rxerror_i = 1'b0;
      for (int k = 0; k < row_post[i]; k++) begin
         fe_data_i    = next_filler(row_pattern[i][7:0]);
         fe_rxvalid_i = 1'b1;
         @(negedge fe_clk);
      end
      fe_rxvalid_i  = 1'b0;
      fe_rxactive_i = 1'b0;
   endtask

   task automatic check_trigger(input int i);
      int   edges;
      int   high;
      int   exp_w;
      int   fired;
      logic seen;
      edges = 0;
      high  = 0;
      fired = 0;
      seen  = 1'b0;
      exp_w = (row_width[i] == 0) ? 1 : int'(row_width[i]);
      @(posedge fe_clk);   // this edge samples rxactive low
      if (row_trig[i]) begin
         while (!seen && edges < int'(row_delay[i]) + 8) begin
            @(posedge fe_clk);
            edges++;
            @(negedge fe_clk);
            seen = cw_trig_o || mcx_trig_o;
         end
         assert (seen)
         else begin
            errors++;
            $display("error in %s: trigger did not rise within %0d cycles", cur_test, edges);
         end
         if (seen) begin
            compare_value("trigger delay", row_delay[i] + 32'd2, 32'(edges));
            while ((cw_trig_o || mcx_trig_o) && high <= exp_w + 4) begin
               compare_value("cw_trig_o", 32'h1, 32'(cw_trig_o));
               compare_value("mcx_trig_o", 32'h1, 32'(mcx_trig_o));
               high++;
               @(negedge fe_clk);
            end
            compare_value("pulse width", 32'(exp_w), 32'(high));
         end
      end
      else begin
         @(negedge fe_clk);
         repeat (row_delay[i] + row_width[i] + 10) begin
            if (cw_trig_o || mcx_trig_o)
               fired++;
            @(negedge fe_clk);
         end
         compare_value("trigger cycles", 32'h0, 32'(fired));
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin : main
      logic [31:0] rd;
      logic        err;
      logic [7:0]  exp_count;
      logic        exp_armed;
      paddr_i       = '0;
      psel_i        = 1'b0;
      penable_i     = 1'b0;
      pwrite_i      = 1'b0;
      pwdata_i      = '0;
      fe_data_i     = '0;
      fe_rxvalid_i  = 1'b0;
      fe_rxactive_i = 1'b0;
      fe_rxerror_i  = 1'b0;
      reset_i       = 1'b1;
      exp_count     = '0;
      exp_armed     = 1'b0;
      load_table();
      rows_loaded = 1'b1;
      repeat (RESET_CYCLES) @(negedge fe_clk);
      reset_i = 1'b0;

      read_check("status", `SNIFF_REG_STATUS, status_word(1'b0, 8'd0));
      for (int i = 0; i < NROWS; i++) begin
         cur_test = row_name[i];
         configure_row(i);
         if (row_arm[i]) begin
            write_reg(`SNIFF_REG_CTRL, 32'h1);
            exp_armed = 1'b1;
            read_check("status after arm", `SNIFF_REG_STATUS, status_word(exp_armed, exp_count));
         end
         send_packet(i);
         check_trigger(i);
         if (row_trig[i]) begin   // a fired trigger disarms the one-shot
            exp_armed = 1'b0;
            exp_count = exp_count + 8'd1;
         end
         read_check("status", `SNIFF_REG_STATUS, status_word(exp_armed, exp_count));
      end

      cur_test = "unmapped_access";
      apb_write(8'h20, 32'hDEAD_BEEF, err);
      compare_value("pslverr on unmapped write", 32'h1, 32'(err));
      apb_read(8'h40, rd, err);
      compare_value("pslverr on unmapped read", 32'h1, 32'(err));
      readback_row(NROWS - 1);

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   initial begin : watchdog
      int limit;
      wait (rows_loaded);
      limit = RESET_CYCLES + TAIL_CYCLES;
      for (int i = 0; i < NROWS; i++)
         limit += row_pre[i] + 8 + row_post[i] + int'(row_delay[i]) + int'(row_width[i]) + 50;
      repeat (limit) @(posedge fe_clk);
      $display("watchdog timeout after %0d cycles while running %s", limit, cur_test);
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- files.f
+incdir+common
common/sniff_pkg.sv
src/apb_regs.sv
trigger/pattern_matcher.sv
trigger/packet_monitor.sv
trigger/trigger_gen.sv
src/sniff_top.sv
test/tb_sniff.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sniff
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
